/* Bender.yml */
package:
  name: ex_unit

sources:
  - files:
      - src/ex_pkg.sv
      - src/alu_control.sv
      - src/int_alu.sv
      - src/mul_pipe.sv
      - src/div_iter.sv
      - src/ex_sequencer.sv
      - src/ex_unit.sv
  - target: test
    files:
      - dv/ex_unit_sva.sv
      - dv/ex_checker.sv
      - dv/tb_ex_unit.sv

/* dv/ex_checker.sv */
module ex_checker import ex_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 out_valid,
    input  logic [XLEN-1:0]      out_data,
    input  logic [TAG_W-1:0]     out_tag,
    input  logic                 exp_valid,
    input  logic [TAG_W-1:0]     exp_tag,
    input  logic [4:0]           exp_op,
    input  logic [XLEN-1:0]      exp_data,
    input  logic                 done,
    output logic [2**TAG_W-1:0]  pending,
    output int                   n_tests,
    output int                   n_errors
);

    logic [XLEN-1:0] want  [2**TAG_W];
    logic [4:0]      op_of [2**TAG_W];

    // codes with no enum member still get a readable name
    function automatic string op_name(logic [4:0] code);
        alu_t t;
        t = alu_t'(code);
        if (t.name() == "") begin
            return $sformatf("op_%05b", code);
        end
        return t.name();
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            pending  = '0;
            n_tests  = 0;
            n_errors = 0;
        end else begin
            if (out_valid) begin
                if (!pending[out_tag]) begin
                    $display("result for tag %0d arrived with no operation outstanding", out_tag);
                    n_errors++;
                end else begin
                    pending[out_tag] = 1'b0;
                    n_tests++;
                    if (out_data !== want[out_tag]) begin
                        $display("ERR %s tag %0d expected %08h actual %08h",
                                 op_name(op_of[out_tag]), out_tag, want[out_tag], out_data);
                        n_errors++;
                    end else begin
                        $display("ok  %s tag %0d result %08h",
                                 op_name(op_of[out_tag]), out_tag, out_data);
                    end
                end
            end
            // new issue recorded after the result check of the same edge
            if (exp_valid) begin
                pending[exp_tag] = 1'b1;
                want[exp_tag]    = exp_data;
                op_of[exp_tag]   = exp_op;
            end
        end
    end

    // anything still outstanding at the end never came back
    always @(posedge done) begin
        for (int t = 0; t < 2**TAG_W; t++) begin
            if (pending[t]) begin
                $display("missing result for tag %0d (%s)", t, op_name(op_of[t]));
                n_errors++;
            end
        end
    end

endmodule : ex_checker

/* dv/ex_unit_sva.sv */
module ex_unit_sva import ex_pkg::*; (
    input logic                 clk,
    input logic                 rst,
    input logic                 out_valid,
    input logic                 out_credit,
    input logic [IN_PTR_W:0]    iq_cnt,
    input logic [OUT_PTR_W:0]   inflight
);

    // read by the testbench top at the end of the run
    int sva_errors = 0;
    // result credits granted and spent since reset
    int granted;
    int spent;

    always_ff @(posedge clk) begin
        if (rst) begin
            granted <= 0;
            spent   <= 0;
        end else begin
            granted <= granted + int'(out_credit);
            spent   <= spent + int'(out_valid);
        end
    end

    a_out_credit: assert property (@(posedge clk) disable iff (rst)
        out_valid |-> granted > spent)
        else begin
            sva_errors++;
            $error("out_valid raised with zero output credit");
        end

    a_iq_bound: assert property (@(posedge clk) disable iff (rst) iq_cnt <= IN_DEPTH)
        else begin
            sva_errors++;
            $error("input queue overflow, count %0d", iq_cnt);
        end

    a_inflight: assert property (@(posedge clk) disable iff (rst) inflight <= OUT_DEPTH)
        else begin
            sva_errors++;
            $error("in-flight count %0d above result queue depth", inflight);
        end

endmodule : ex_unit_sva

bind ex_sequencer ex_unit_sva u_sva (
    .clk(clk), .rst(rst), .out_valid(out_valid), .out_credit(out_credit),
    .iq_cnt(iq_cnt), .inflight(inflight)
);

/* dv/tb_ex_unit.sv */
module tb_ex_unit import ex_pkg::*; ();

    localparam int N_OPS   = 200;
    localparam int TIMEOUT = N_OPS * (DIV_CYCLES + 8);

    logic                clk = 1'b0;
    logic                rst;
    logic                in_valid, in_credit, out_valid, out_credit;
    logic [1:0]          in_alu_op;
    logic [2:0]          in_fun3;
    logic [6:0]          in_fun7;
    logic [XLEN-1:0]     in_a, in_b, out_data;
    logic [TAG_W-1:0]    in_tag, out_tag, next_tag;
    logic                exp_valid, done;
    logic [TAG_W-1:0]    exp_tag;
    logic [4:0]          exp_op;
    logic [XLEN-1:0]     exp_data;
    logic [2**TAG_W-1:0] pending;
    integer              seed;
    int                  credits, issued, n_tests, n_errors, total;
    int                  cycles = 0;
    int                  tb_errors = 0;

    always #5 clk = ~clk;

    ex_unit dut (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_alu_op(in_alu_op), .in_fun3(in_fun3), .in_fun7(in_fun7),
        .in_a(in_a), .in_b(in_b), .in_tag(in_tag), .in_credit(in_credit),
        .out_valid(out_valid), .out_data(out_data), .out_tag(out_tag),
        .out_credit(out_credit)
    );

    ex_checker chk (
        .clk(clk), .rst(rst), .out_valid(out_valid), .out_data(out_data), .out_tag(out_tag),
        .exp_valid(exp_valid), .exp_tag(exp_tag), .exp_op(exp_op), .exp_data(exp_data),
        .done(done), .pending(pending), .n_tests(n_tests), .n_errors(n_errors)
    );

    // operation code from the decode rules
    function automatic logic [4:0] decode_op(logic [1:0] op, logic [2:0] f3, logic [6:0] f7);
        case (op)
            ALU_OP_R:  return f7[0] ? {2'b10, f3} : {1'b0, f7[5], f3};
            ALU_OP_I:  return (f3 == 3'd5) ? {1'b0, f7[5], f3} : {2'b00, f3};
            ALU_OP_LS: return ADD;
            default:   return (f3 < 3'd4) ? SUB : ((f3 < 3'd6) ? SLT : SLTU);
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_result(logic [4:0] code, logic [XLEN-1:0] a,
                                                     logic [XLEN-1:0] b);
        logic [63:0] xa, xb, prod;
        logic        ovf;
        xa   = (code == MULH || code == MULHSU) ? {{32{a[31]}}, a} : {32'b0, a};
        xb   = (code == MULH) ? {{32{b[31]}}, b} : {32'b0, b};
        prod = xa * xb;
        ovf  = (a == 32'h8000_0000) && (b == '1);
        case (code)
            ADD:  return a + b;
            SUB:  return a - b;
            SLL:  return a << b[4:0];
            SLT:  return {31'b0, $signed(a) < $signed(b)};
            SLTU: return {31'b0, a < b};
            XOR:  return a ^ b;
            SRL:  return a >> b[4:0];
            SRA:  return $signed(a) >>> b[4:0];
            OR:   return a | b;
            AND:  return a & b;
            MUL:  return prod[31:0];
            MULH, MULHSU, MULHU: return prod[63:32];
            DIV, REM: begin
                if (b == '0) begin
                    return (code == DIV) ? '1 : a;
                end
                if (ovf) begin
                    return (code == DIV) ? a : '0;
                end
                if (code == DIV) begin
                    return $signed(a) / $signed(b);
                end
                return $signed(a) % $signed(b);
            end
            DIVU: return (b == '0) ? '1 : a / b;
            REMU: return (b == '0) ? a : a % b;
            // R-type alt codes outside the base set
            default: return '0;
        endcase
    endfunction

    task automatic issue_op();
        logic [XLEN-1:0] a, b;
        logic [4:0]      code;
        int              pick;
        // half the ops are R-type so M codes come up often
        in_alu_op  = ({$random(seed)} % 2) ? ALU_OP_R : 2'($random(seed));
        in_fun3    = 3'($random(seed));
        in_fun7    = 7'b0;
        in_fun7[5] = 1'($random(seed));
        in_fun7[0] = 1'($random(seed));
        a    = $random(seed);
        b    = $random(seed);
        pick = {$random(seed)} % 8;
        // bias toward divide corner cases and short shifts
        case (pick)
            0: b = '0;
            1: begin
                a = 32'h8000_0000;
                b = '1;
            end
            2: b = b & 32'h1f;
            default: ;
        endcase
        code      = decode_op(in_alu_op, in_fun3, in_fun7);
        in_a      = a;
        in_b      = b;
        in_tag    = next_tag;
        in_valid  = 1'b1;
        exp_valid = 1'b1;
        exp_tag   = next_tag;
        exp_op    = code;
        exp_data  = model_result(code, a, b);
        next_tag  = next_tag + 1'b1;
        issued++;
    endtask

    // issuer credit count against the IN_DEPTH bound
    always @(posedge clk) begin
        if (rst) begin
            credits <= IN_DEPTH;
        end else begin
            if (in_credit && (credits - int'(in_valid)) >= IN_DEPTH) begin
                $display("in_credit pulse arrived with the credit count already full");
                tb_errors++;
            end
            credits <= credits - int'(in_valid) + int'(in_credit);
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == TIMEOUT) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycles, $countones(pending));
            done = 1'b1;
            #1;
            $display("test failed");
            $finish;
        end
    end

    initial begin
        seed       = 11;
        rst        = 1'b1;
        in_valid   = 1'b0;
        in_alu_op  = '0;
        in_fun3    = '0;
        in_fun7    = '0;
        in_a       = '0;
        in_b       = '0;
        in_tag     = '0;
        out_credit = 1'b0;
        exp_valid  = 1'b0;
        exp_tag    = '0;
        exp_op     = '0;
        exp_data   = '0;
        done       = 1'b0;
        next_tag   = '0;
        issued     = 0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        // exp_valid keeps the loop alive until the last issue is recorded
        while (issued < N_OPS || pending != '0 || exp_valid) begin
            @(posedge clk);
            #1;
            in_valid  = 1'b0;
            exp_valid = 1'b0;
            if (issued < N_OPS && credits > 0 && !pending[next_tag]) begin
                issue_op();
            end
            // consumer grants a result slot about 40 percent of cycles
            out_credit = ({$random(seed)} % 10) < 4;
        end
        in_valid   = 1'b0;
        out_credit = 1'b0;
        done       = 1'b1;
        #1;
        total = n_errors + tb_errors + dut.u_seq.u_sva.sva_errors;
        $display("%0d operations checked, %0d errors", n_tests, total);
        if (total == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule : tb_ex_unit

/* filelist.f */
src/ex_pkg.sv
src/alu_control.sv
src/int_alu.sv
src/mul_pipe.sv
src/div_iter.sv
src/ex_sequencer.sv
src/ex_unit.sv
dv/ex_unit_sva.sv
dv/ex_checker.sv
dv/tb_ex_unit.sv

/* src/alu_control.sv */
module alu_control import ex_pkg::*; (
    input  logic [2:0] fun3,
    input  logic [6:0] fun7,
    input  logic [1:0] alu_op,
    output alu_t       alu_ctrl,
    // set for any MUL/DIV/REM operation
    output logic       m_type,
    output logic       divide_instruction
);

    always_comb begin
        // defaults keep every path assigned
        alu_ctrl           = ADD;
        m_type             = 1'b0;
        divide_instruction = 1'b0;

        case (alu_op)
            ALU_OP_R: begin
                if (fun7[0]) begin
                    m_type = 1'b1;
                    case (fun3)
                        3'b000: alu_ctrl = MUL;
                        3'b001: alu_ctrl = MULH;
                        3'b010: alu_ctrl = MULHSU;
                        3'b011: alu_ctrl = MULHU;
                        3'b100: alu_ctrl = DIV;
                        3'b101: alu_ctrl = DIVU;
                        3'b110: alu_ctrl = REM;
                        default: alu_ctrl = REMU;
                    endcase
                    // upper half of fun3 is the divide group
                    divide_instruction = fun3[2];
                end else begin
                    alu_ctrl = alu_t'({1'b0, fun7[5], fun3});
                end
            end

            ALU_OP_I: begin
                // only shift right looks at fun7[5]
                if (fun3 == 3'b101) begin
                    alu_ctrl = alu_t'({1'b0, fun7[5], fun3});
                end else begin
                    alu_ctrl = alu_t'({2'b00, fun3});
                end
            end

            ALU_OP_LS: begin
                // address generation
                alu_ctrl = ADD;
            end

            default: begin
                // branch compare
                case (fun3[2:1])
                    2'b00, 2'b01: alu_ctrl = SUB;
                    2'b10:   alu_ctrl = SLT;
                    default: alu_ctrl = SLTU;
                endcase
            end
        endcase
    end

endmodule : alu_control

/* src/div_iter.sv */
module div_iter import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  op_word_u         op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [TAG_W-1:0] tag,
    output logic             busy,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);

    logic [DIV_CNT_W-1:0] cnt;
    logic [XLEN-1:0]      quo, rem, dvs, dividend;
    logic                 is_rem, neg_q, neg_r, div0;
    logic [XLEN:0]        rem_sh, diff;
    logic                 take;
    logic                 a_neg, b_neg;
    logic [XLEN-1:0]      q_fix, r_fix;

    // DIV and REM are the signed forms
    assign a_neg = !op.f.f3[0] && a[XLEN-1];
    assign b_neg = !op.f.f3[0] && b[XLEN-1];

    // one restoring step per cycle
    assign rem_sh = {rem, quo[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs};
    assign take   = (rem_sh >= {1'b0, dvs});

    always_ff @(posedge clk) begin
        if (rst) begin
            busy      <= 1'b0;
            cnt       <= '0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                cnt  <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                if (cnt == DIV_CNT_W'(DIV_CYCLES - 1)) begin
                    busy      <= 1'b0;
                    res_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            quo      <= a_neg ? -a : a;
            dvs      <= b_neg ? -b : b;
            rem      <= '0;
            dividend <= a;
            is_rem   <= op.f.f3[1];
            neg_q    <= a_neg ^ b_neg;
            neg_r    <= a_neg;
            div0     <= (b == '0);
            res_tag  <= tag;
        end else if (busy) begin
            quo <= {quo[XLEN-2:0], take};
            rem <= take ? diff[XLEN-1:0] : rem_sh[XLEN-1:0];
        end
    end

    // signs go back on after the last step
    assign q_fix = neg_q ? -quo : quo;
    assign r_fix = neg_r ? -rem : rem;

    // most negative / -1 needs no special case, the magnitude path gives it
    always_comb begin
        if (is_rem) begin
            res_data = div0 ? dividend : r_fix;
        end else begin
            res_data = div0 ? '1 : q_fix;
        end
    end

endmodule : div_iter

/* src/ex_pkg.sv */
package ex_pkg;

    // datapath sizing
    localparam int XLEN       = 32;
    localparam int TAG_W      = 4;
    localparam int IN_DEPTH   = 4;
    localparam int OUT_DEPTH  = 8;
    localparam int DIV_CYCLES = 32;

    localparam int IN_PTR_W  = $clog2(IN_DEPTH);
    localparam int OUT_PTR_W = $clog2(OUT_DEPTH);
    localparam int DIV_CNT_W = $clog2(DIV_CYCLES);
    // wide enough that consumer grants never wrap within a run
    localparam int OCRED_W   = 16;

    // alu_op encodings from the decode stage
    localparam logic [1:0] ALU_OP_LS = 2'b00;
    localparam logic [1:0] ALU_OP_I  = 2'b01;
    localparam logic [1:0] ALU_OP_R  = 2'b11;
    localparam logic [1:0] ALU_OP_B  = 2'b10;

    // base codes are {fun7[5], fun3}, M codes carry bit 4
    typedef enum logic [4:0] {
        ADD  = 5'b00000, SLL  = 5'b00001, SLT    = 5'b00010, SLTU  = 5'b00011,
        XOR  = 5'b00100, SRL  = 5'b00101, OR     = 5'b00110, AND   = 5'b00111,
        SUB  = 5'b01000, SRA  = 5'b01101,
        MUL  = 5'b10000, MULH = 5'b10001, MULHSU = 5'b10010, MULHU = 5'b10011,
        DIV  = 5'b10100, DIVU = 5'b10101, REM    = 5'b10110, REMU  = 5'b10111
    } alu_t;

    typedef struct packed {
        logic       m;
        logic       alt;
        logic [2:0] f3;
    } op_fields_t;

    // same op word seen as an opcode or as raw fields
    typedef union packed {
        alu_t       op;
        op_fields_t f;
    } op_word_u;

endpackage : ex_pkg

/* src/ex_sequencer.sv */
module ex_sequencer import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [1:0]       in_alu_op,
    input  logic [2:0]       in_fun3,
    input  logic [6:0]       in_fun7,
    input  logic [XLEN-1:0]  in_a,
    input  logic [XLEN-1:0]  in_b,
    input  logic [TAG_W-1:0] in_tag,
    output logic             in_credit,
    output logic [1:0]       dec_alu_op,
    output logic [2:0]       dec_fun3,
    output logic [6:0]       dec_fun7,
    input  op_word_u         dec_op,
    input  logic             dec_div,
    output logic             alu_start,
    output logic             mul_start,
    output logic             div_start,
    output op_word_u         iss_op,
    output logic [XLEN-1:0]  iss_a,
    output logic [XLEN-1:0]  iss_b,
    output logic [TAG_W-1:0] iss_tag,
    input  logic             div_busy,
    input  logic             alu_valid,
    input  logic [XLEN-1:0]  alu_data,
    input  logic [TAG_W-1:0] alu_tag,
    input  logic             mul_valid,
    input  logic [XLEN-1:0]  mul_data,
    input  logic [TAG_W-1:0] mul_tag,
    input  logic             div_valid,
    input  logic [XLEN-1:0]  div_data,
    input  logic [TAG_W-1:0] div_tag,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_data,
    output logic [TAG_W-1:0] out_tag,
    input  logic             out_credit
);

    logic [1:0]       iq_alu_op [IN_DEPTH];
    logic [2:0]       iq_fun3   [IN_DEPTH];
    logic [6:0]       iq_fun7   [IN_DEPTH];
    logic [XLEN-1:0]  iq_a      [IN_DEPTH];
    logic [XLEN-1:0]  iq_b      [IN_DEPTH];
    logic [TAG_W-1:0] iq_tag    [IN_DEPTH];
    logic [XLEN-1:0]  oq_data   [OUT_DEPTH];
    logic [TAG_W-1:0] oq_tag    [OUT_DEPTH];

    logic [IN_PTR_W-1:0]  iq_wr, iq_rd;
    logic [IN_PTR_W:0]    iq_cnt;
    logic [OUT_PTR_W-1:0] oq_wr, oq_rd;
    logic [OUT_PTR_W:0]   oq_cnt, inflight;
    logic [OCRED_W-1:0]   ocred;
    logic                 to_alu, to_mul, to_div, room, dispatch;
    logic [1:0]           n_wr, off_mul, off_alu;

    // head of the input queue goes to the decoder
    assign dec_alu_op = iq_alu_op[iq_rd];
    assign dec_fun3   = iq_fun3[iq_rd];
    assign dec_fun7   = iq_fun7[iq_rd];

    // unit select from the field view
    assign to_alu = !dec_op.f.m;
    assign to_div = dec_op.f.m && dec_div;
    assign to_mul = dec_op.f.m && !dec_div;

    // every dispatched op owns a result queue slot
    assign room     = ({1'b0, inflight} + {1'b0, oq_cnt}) < (OUT_PTR_W + 2)'(OUT_DEPTH);
    assign dispatch = (iq_cnt != '0) && room && !(to_div && div_busy);

    assign alu_start = dispatch && to_alu;
    assign mul_start = dispatch && to_mul;
    assign div_start = dispatch && to_div;
    assign iss_op    = dec_op;
    assign iss_a     = iq_a[iq_rd];
    assign iss_b     = iq_b[iq_rd];
    assign iss_tag   = iq_tag[iq_rd];

    // write order is divider, multiplier, ALU
    assign off_mul = 2'(div_valid);
    assign off_alu = 2'(div_valid) + 2'(mul_valid);
    assign n_wr    = off_alu + 2'(alu_valid);

    assign out_valid = (oq_cnt != '0) && (ocred != '0);
    assign out_data  = oq_data[oq_rd];
    assign out_tag   = oq_tag[oq_rd];

    always_ff @(posedge clk) begin
        if (in_valid) begin
            iq_alu_op[iq_wr] <= in_alu_op;
            iq_fun3[iq_wr]   <= in_fun3;
            iq_fun7[iq_wr]   <= in_fun7;
            iq_a[iq_wr]      <= in_a;
            iq_b[iq_wr]      <= in_b;
            iq_tag[iq_wr]    <= in_tag;
        end
        if (div_valid) begin
            oq_data[oq_wr] <= div_data;
            oq_tag[oq_wr]  <= div_tag;
        end
        if (mul_valid) begin
            oq_data[oq_wr + OUT_PTR_W'(off_mul)] <= mul_data;
            oq_tag[oq_wr + OUT_PTR_W'(off_mul)]  <= mul_tag;
        end
        if (alu_valid) begin
            oq_data[oq_wr + OUT_PTR_W'(off_alu)] <= alu_data;
            oq_tag[oq_wr + OUT_PTR_W'(off_alu)]  <= alu_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            iq_wr     <= '0;
            iq_rd     <= '0;
            iq_cnt    <= '0;
            oq_wr     <= '0;
            oq_rd     <= '0;
            oq_cnt    <= '0;
            inflight  <= '0;
            ocred     <= '0;
            in_credit <= 1'b0;
        end else begin
            iq_wr    <= iq_wr + IN_PTR_W'(in_valid);
            iq_rd    <= iq_rd + IN_PTR_W'(dispatch);
            iq_cnt   <= iq_cnt + (IN_PTR_W + 1)'(in_valid) - (IN_PTR_W + 1)'(dispatch);
            oq_wr    <= oq_wr + OUT_PTR_W'(n_wr);
            oq_rd    <= oq_rd + OUT_PTR_W'(out_valid);
            oq_cnt   <= oq_cnt + (OUT_PTR_W + 1)'(n_wr) - (OUT_PTR_W + 1)'(out_valid);
            inflight <= inflight + (OUT_PTR_W + 1)'(dispatch) - (OUT_PTR_W + 1)'(n_wr);
            ocred    <= ocred + OCRED_W'(out_credit) - OCRED_W'(out_valid);
            // freed input slot goes back to the issuer
            in_credit <= dispatch;
        end
    end

endmodule : ex_sequencer

/* src/ex_unit.sv */
module ex_unit import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             in_valid,
    input  logic [1:0]       in_alu_op,
    input  logic [2:0]       in_fun3,
    input  logic [6:0]       in_fun7,
    input  logic [XLEN-1:0]  in_a,
    input  logic [XLEN-1:0]  in_b,
    input  logic [TAG_W-1:0] in_tag,
    output logic             in_credit,
    output logic             out_valid,
    output logic [XLEN-1:0]  out_data,
    output logic [TAG_W-1:0] out_tag,
    input  logic             out_credit
);

    logic [1:0]       dec_alu_op;
    logic [2:0]       dec_fun3;
    logic [6:0]       dec_fun7;
    op_word_u         dec_op, iss_op;
    logic             dec_div;
    logic             alu_start, mul_start, div_start, div_busy;
    logic [XLEN-1:0]  iss_a, iss_b;
    logic [TAG_W-1:0] iss_tag;
    logic             alu_valid, mul_valid, div_valid;
    logic [XLEN-1:0]  alu_data, mul_data, div_data;
    logic [TAG_W-1:0] alu_tag, mul_tag, div_tag;

    // the m bit of the op word stands in for m_type
    alu_control u_ctrl (
        .fun3(dec_fun3), .fun7(dec_fun7), .alu_op(dec_alu_op),
        .alu_ctrl(dec_op.op), .m_type(), .divide_instruction(dec_div)
    );

    ex_sequencer u_seq (
        .clk(clk), .rst(rst),
        .in_valid(in_valid), .in_alu_op(in_alu_op), .in_fun3(in_fun3), .in_fun7(in_fun7),
        .in_a(in_a), .in_b(in_b), .in_tag(in_tag), .in_credit(in_credit),
        .dec_alu_op(dec_alu_op), .dec_fun3(dec_fun3), .dec_fun7(dec_fun7),
        .dec_op(dec_op), .dec_div(dec_div),
        .alu_start(alu_start), .mul_start(mul_start), .div_start(div_start),
        .iss_op(iss_op), .iss_a(iss_a), .iss_b(iss_b), .iss_tag(iss_tag),
        .div_busy(div_busy),
        .alu_valid(alu_valid), .alu_data(alu_data), .alu_tag(alu_tag),
        .mul_valid(mul_valid), .mul_data(mul_data), .mul_tag(mul_tag),
        .div_valid(div_valid), .div_data(div_data), .div_tag(div_tag),
        .out_valid(out_valid), .out_data(out_data), .out_tag(out_tag),
        .out_credit(out_credit)
    );

    int_alu u_alu (
        .clk(clk), .rst(rst), .start(alu_start), .op(iss_op),
        .a(iss_a), .b(iss_b), .tag(iss_tag),
        .res_valid(alu_valid), .res_data(alu_data), .res_tag(alu_tag)
    );

    mul_pipe u_mul (
        .clk(clk), .rst(rst), .start(mul_start), .op(iss_op),
        .a(iss_a), .b(iss_b), .tag(iss_tag),
        .res_valid(mul_valid), .res_data(mul_data), .res_tag(mul_tag)
    );

    div_iter u_div (
        .clk(clk), .rst(rst), .start(div_start), .op(iss_op),
        .a(iss_a), .b(iss_b), .tag(iss_tag), .busy(div_busy),
        .res_valid(div_valid), .res_data(div_data), .res_tag(div_tag)
    );

endmodule : ex_unit

/* src/int_alu.sv */
module int_alu import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  op_word_u         op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [TAG_W-1:0] tag,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);

    logic [XLEN-1:0] result;
    logic [4:0]      shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op.op)
            ADD:  result = a + b;
            SUB:  result = a - b;
            SLL:  result = a << shamt;
            SLT:  result = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            SLTU: result = {{(XLEN-1){1'b0}}, a < b};
            XOR:  result = a ^ b;
            SRL:  result = a >> shamt;
            SRA:  result = $signed(a) >>> shamt;
            OR:   result = a | b;
            AND:  result = a & b;
            // codes outside the base set read as zero
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= start;
        end
    end

    // payload captured with start
    always_ff @(posedge clk) begin
        if (start) begin
            res_data <= result;
            res_tag  <= tag;
        end
    end

endmodule : int_alu

/* src/mul_pipe.sv */
module mul_pipe import ex_pkg::*; (
    input  logic             clk,
    input  logic             rst,
    input  logic             start,
    input  op_word_u         op,
    input  logic [XLEN-1:0]  a,
    input  logic [XLEN-1:0]  b,
    input  logic [TAG_W-1:0] tag,
    output logic             res_valid,
    output logic [XLEN-1:0]  res_data,
    output logic [TAG_W-1:0] res_tag
);

    logic                   s1_valid, s2_valid;
    logic signed [XLEN:0]   s1_a, s1_b;
    logic        [2:0]      s1_f3, s2_f3;
    logic [TAG_W-1:0]       s1_tag;
    logic signed [2*XLEN+1:0] s2_prod;
    logic                   a_sgn, b_sgn;

    // MULHU is fully unsigned, MULHSU only signs operand a
    assign a_sgn = (op.f.f3 != 3'b011);
    assign b_sgn = !op.f.f3[1];

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= start;
            s2_valid <= s1_valid;
        end
    end

    // stage one extends, stage two multiplies
    always_ff @(posedge clk) begin
        s1_a    <= {a_sgn & a[XLEN-1], a};
        s1_b    <= {b_sgn & b[XLEN-1], b};
        s1_f3   <= op.f.f3;
        s1_tag  <= tag;
        s2_prod <= s1_a * s1_b;
        s2_f3   <= s1_f3;
        res_tag <= s1_tag;
    end

    assign res_valid = s2_valid;
    // low word only for plain MUL
    assign res_data  = (s2_f3 == 3'b000) ? s2_prod[XLEN-1:0] : s2_prod[2*XLEN-1:XLEN];

endmodule : mul_pipe
